//--- ide_bridge.sv
/* z80 to 16 bit ide bridge, nemo ports,
   divide byte order triggers and data registers */
`timescale 1ns/1ps
`default_nettype none
`include "zports_params.svh"

module ide_bridge import zports_pkg::*; (
	input  wire       zclk,
	input  wire       rst_n,
	port_bus_if.snk   bus,
	input  wire ide_word_t idein,
	output ide_word_t ideout,
	output byte_t     ide_rd_data, // to the read mux
	output logic      idedataout,  // low while the ide drive talks
	output ide_reg_t  ide_a,
	output logic      ide_cs0_n,
	output logic      ide_cs1_n,
	output logic      ide_rd_n,
	output logic      ide_wr_n
);

	byte_t     loa;
	logic      ide_ports;   // physical ports, #11 is not one
	logic      ide_acc;     // any nemo port strobe
	logic      lo_rd;       // #10 read that fetches a new word
	logic      is_10, is_11;
	logic      rd_trig;     // divide read: high byte pending
	logic      wrlo_trig;   // divide write: low byte stored
	logic      wrhi_trig;   // normal write: high byte stored
	logic      rd_latch, wrlo_latch, wrhi_latch;
	byte_t     hi_in;       // captured idein[15:8]
	ide_word_t wr_reg;      // prewritten half

	assign loa   = bus.addr[7:0];
	assign is_10 = (loa == `IDE_10);
	assign is_11 = (loa == `IDE_11);

	always_comb
	begin
		case (loa)
		`IDE_10, `IDE_30, `IDE_50, `IDE_70, `IDE_90,
		`IDE_B0, `IDE_D0, `IDE_F0, `IDE_C8:
			ide_ports = 1'b1;
		default:
			ide_ports = 1'b0;
		endcase
	end

	assign ide_acc = (ide_ports || is_11) && (bus.port_rd || bus.port_wr);
	assign lo_rd   = bus.port_rd && is_10 && !rd_trig;

	////////////////////////////////////////////////////////////
	// sequencing triggers

	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
			rd_trig <= 1'b0;
		else if (lo_rd)
			rd_trig <= 1'b1;  // next #10 read is the high byte
		else if (ide_acc)
			rd_trig <= 1'b0;
	end

	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			wrhi_trig <= 1'b0;
			wrlo_trig <= 1'b0;
		end
		else if (ide_acc)
		begin
			wrhi_trig <= is_11 && bus.port_wr;
			wrlo_trig <= is_10 && bus.port_wr && !wrhi_trig && !wrlo_trig;
		end
	end

	// triggers move during the access itself, so hold them across it
	always_latch if (bus.rd_n) rd_latch <= rd_trig;
	always_latch if (bus.wr_n) wrlo_latch <= wrlo_trig;
	always_latch if (bus.wr_n) wrhi_latch <= wrhi_trig;

	// data registers
	always_ff @(posedge zclk)
	begin
		if (bus.port_wr && is_11)
			wr_reg[15:8] <= bus.data;
		if (bus.port_wr && is_10 && !wrlo_trig)
			wr_reg[7:0] <= bus.data;
		if (lo_rd)
			hi_in <= idein[15:8];
	end

	////////////////////////////////////////////////////////////
	// ide pins

	assign ide_a     = bus.addr[7:5];
	assign ide_cs0_n = ~ide_ports | (loa == `IDE_C8);
	assign ide_cs1_n = ~ide_ports | (loa != `IDE_C8);

	// second #10 read of divide order serves the stored byte
	assign ide_rd_n = bus.iorq_n | bus.rd_n | ~ide_ports | (rd_latch & is_10);
	// first #10 write of divide order only stores
	assign ide_wr_n = bus.iorq_n | bus.wr_n | ~ide_ports |
	                  (is_10 & ~wrlo_latch & ~wrhi_latch);

	assign idedataout = ide_rd_n;

	assign ide_rd_data = (is_11 || (rd_latch && is_10)) ? hi_in : idein[7:0];

	assign ideout[15:8] = wrhi_latch ? wr_reg[15:8] : bus.data;
	assign ideout[7:0]  = wrlo_latch ? wr_reg[7:0]  : bus.data;

endmodule

`default_nettype wire

//--- io_strobe_gen.sv
/* z80 i/o write and read strobe detection,
   drives the internal port bus */
`timescale 1ns/1ps
`default_nettype none

module io_strobe_gen import zports_pkg::*; (
	input  wire      zclk,
	input  wire      rst_n,
	input  wire io_addr_t a,
	input  wire byte_t    din,
	input  wire      iorq_n,
	input  wire      rd_n,
	input  wire      wr_n,
	input  wire      dos,
	port_bus_if.src  bus
);

	logic iowr_reg, iord_reg; // access level, one edge old
	logic port_wr, port_rd;
	logic iowr_now, iord_now;

	assign iowr_now = ~(iorq_n | wr_n); // io write in progress
	assign iord_now = ~(iorq_n | rd_n);

	// rising edge of the access level gives one pulse
	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			iowr_reg <= 1'b0;
			iord_reg <= 1'b0;
			port_wr  <= 1'b0;
			port_rd  <= 1'b0;
		end
		else
		begin
			iowr_reg <= iowr_now;
			iord_reg <= iord_now;
			port_wr  <= iowr_now & ~iowr_reg; // once per access
			port_rd  <= iord_now & ~iord_reg;
		end
	end

	// bus fan-out
	assign bus.addr    = a;
	assign bus.data    = din;
	assign bus.iorq_n  = iorq_n;
	assign bus.rd_n    = rd_n;
	assign bus.wr_n    = wr_n;
	assign bus.shadow  = dos; // no shadow enable port here
	assign bus.port_wr = port_wr;
	assign bus.port_rd = port_rd;

endmodule

`default_nettype wire

//--- mem_pager.sv
/* 7ffd and eff7 paging registers, lock rules,
   rom select after reset, pentagon 1m outputs */
`timescale 1ns/1ps
`default_nettype none
`include "zports_params.svh"

module mem_pager import zports_pkg::*, paging_pkg::*; (
	input  wire       zclk,
	input  wire       rst_n,
	port_bus_if.snk   bus,
	input  wire [1:0] rstrom,        // rom to start from
	output byte_t     p7ffd,
	output byte_t     peff7,
	output page1m_t   pent1m_page,
	output logic      pent1m_rom,
	output logic      pent1m_1m_on,
	output logic      pent1m_ram0_0
);

	byte_t     p7ffd_int, peff7_int;
	logic      rom_int;              // 7ffd bit 4 as seen by the pager
	logic      rst_s1, rst_s2;       // reset tail for rom load
	logic      wr_7ffd, wr_eff7;
	logic      block1m, block7ffd;
	ram_page_t page_lo, page_hi;

	assign block1m   = peff7_int[`EFF7_LOCK];
	assign block7ffd = p7ffd_int[`P7FFD_LOCK] & block1m;

	assign wr_7ffd = (bus.addr[7:0] == `PORT_FD) && !bus.addr[15] && bus.port_wr && !block7ffd;
	assign wr_eff7 = (bus.addr[7:0] == `PORT_F7) && bus.addr[8] && !bus.addr[12] &&
	                 bus.port_wr && !bus.shadow; // no eef7 in shadow

	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			p7ffd_int <= `P7FFD_RST;
			peff7_int <= `PEFF7_RST;
		end
		else
		begin
			if (wr_7ffd)
				p7ffd_int <= bus.data;
			if (wr_eff7)
				peff7_int <= bus.data;
		end
	end

	// two stages, still high two edges after release
	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			rst_s1 <= 1'b1;
			rst_s2 <= 1'b1;
		end
		else
		begin
			rst_s1 <= 1'b0;
			rst_s2 <= rst_s1;
		end
	end

	always_ff @(posedge zclk)
	begin
		if (rst_s2)
			rom_int <= rstrom[0];
		else if (wr_7ffd)
			rom_int <= bus.data[`P7FFD_ROM];
	end

	////////////////////////////////////////////////////////////
	// outputs

	assign page_lo = p7ffd_int[2:0];
	assign page_hi = p7ffd_int[7:5];

	assign p7ffd = {(block1m ? 3'b000 : page_hi), rom_int, p7ffd_int[3:0]};
	assign peff7 = block1m ? {peff7_int[7], 1'b0, peff7_int[5:4], 3'b000, peff7_int[0]}
	                       : peff7_int;

	assign pent1m_page   = {page_hi, page_lo};
	assign pent1m_rom    = p7ffd_int[`P7FFD_ROM];
	assign pent1m_1m_on  = ~block1m;
	assign pent1m_ram0_0 = peff7_int[`EFF7_RAM0];

endmodule

`default_nettype wire

//--- paging_pkg.sv
/* memory paging and ula types */
`default_nettype none

package paging_pkg;

	typedef logic [2:0] ram_page_t; // 3 bit page field of 7ffd
	typedef logic [5:0] page1m_t;   // pentagon 1m page, 64 x 16k
	typedef logic [2:0] border_t;   // grb border colour

endpackage

`default_nettype wire

//--- port_bus_if.sv
/* internal z80 i/o bus: address, data, raw levels,
   shadow flag and one-cycle access strobes */
`timescale 1ns/1ps
`default_nettype none

interface port_bus_if import zports_pkg::*; ();

	io_addr_t addr;    // live z80 address
	byte_t    data;    // z80 write data
	logic     iorq_n;  // raw bus levels
	logic     rd_n;
	logic     wr_n;
	logic     shadow;  // dos rom active
	logic     port_wr; // one zclk per i/o write
	logic     port_rd; // one zclk per i/o read

	// strobe generator drives everything
	modport src (output addr, data, iorq_n, rd_n, wr_n, shadow, port_wr, port_rd);

	// port blocks only listen
	modport snk (input addr, data, iorq_n, rd_n, wr_n, shadow, port_wr, port_rd);

endinterface

`default_nettype wire

//--- port_decoder.sv
/* port hit decode, z80 read data mux,
   vg93 chip select and port ff write strobe */
`timescale 1ns/1ps
`default_nettype none
`include "zports_params.svh"

module port_decoder import zports_pkg::*; (
	port_bus_if.snk   bus,
	input  wire byte_t ide_rd_data, // from the ide bridge
	input  wire [4:0] keys_in,      // keyboard half-row
	input  wire       tape_read,
	input  wire       vg_intrq,
	input  wire       vg_drq,
	input  wire [4:0] kj_in,        // kempston joystick
	input  wire byte_t mus_in,      // kempston mouse
	output byte_t     dout,
	output logic      dataout,      // we drive the z80 bus
	output logic      porthit,      // internal port, used for zxbus iorq gating
	output logic      vg_cs_n,
	output logic      vg_wr_ff
);

	byte_t loa;
	logic  ide_hit;  // any nemo ide port incl #11
	logic  vg_port;  // vg93 register ports
	logic  external; // answered off chip

	assign loa = bus.addr[7:0];

	always_comb
	begin
		case (loa)
		`IDE_10, `IDE_11, `IDE_30, `IDE_50, `IDE_70,
		`IDE_90, `IDE_B0, `IDE_D0, `IDE_F0, `IDE_C8:
			ide_hit = 1'b1;
		default:
			ide_hit = 1'b0;
		endcase
	end

	assign vg_port = (loa == `VG_COM) || (loa == `VG_TRK) ||
	                 (loa == `VG_SEC) || (loa == `VG_DAT);

	////////////////////////////////////////////////////////////
	// hit and bus direction

	// vg group only in shadow, kjoy and f7 only outside
	assign porthit = (loa == `PORT_FE) || (loa == `PORT_FD) || ide_hit ||
	                 (loa == `KMOUSE) ||
	                 ((vg_port || (loa == `VG_SYS)) && bus.shadow) ||
	                 (((loa == `KJOY) || (loa == `PORT_F7)) && !bus.shadow);

	// ay data reg and vg registers answer themselves
	assign external = ((loa == `PORT_FD) && (bus.addr[15:14] == 2'b11)) ||
	                  (vg_port && bus.shadow);

	assign dataout = porthit & ~bus.iorq_n & ~bus.rd_n & ~external;

	// read data mux
	always_comb
	begin
		case (loa)
		`PORT_FE:
			dout = {1'b1, tape_read, 1'b0, keys_in};
		`IDE_10, `IDE_11, `IDE_30, `IDE_50, `IDE_70,
		`IDE_90, `IDE_B0, `IDE_D0, `IDE_F0, `IDE_C8:
			dout = ide_rd_data; // even/odd picked in the bridge
		`VG_SYS:
			dout = {vg_intrq, vg_drq, 6'b111111};
		`KJOY:
			dout = {3'b000, kj_in};
		`KMOUSE:
			dout = mus_in;
		default:
			dout = `RD_IDLE; // f7 and fd read back idle too
		endcase
	end

	////////////////////////////////////////////////////////////
	// vg93

	assign vg_cs_n  = ~bus.shadow | bus.iorq_n | (bus.rd_n & bus.wr_n) | ~vg_port;
	assign vg_wr_ff = (loa == `VG_SYS) && bus.shadow && bus.port_wr; // drive/side/density

endmodule

`default_nettype wire

//--- src.f
+incdir+.
zports_pkg.sv
paging_pkg.sv
port_bus_if.sv
io_strobe_gen.sv
port_decoder.sv
ula_ay_ports.sv
ide_bridge.sv
mem_pager.sv
zports_top.sv
tb_zports.sv

//--- tb_zports.sv
/* directed testbench of the z80 port block:
   clock, reset, bus cycle tasks and checks */
`timescale 1ns/1ps
`default_nettype none
`include "zports_params.svh"

module tb_zports import zports_pkg::*, paging_pkg::*; ();

	logic       zclk, rst_n;
	io_addr_t   a;
	byte_t      din, dout, mus_in, p7ffd, peff7;
	logic       iorq_n, rd_n, wr_n, dos, dataout, porthit;
	ide_word_t  idein, ideout;
	ide_reg_t   ide_a;
	logic       idedataout, ide_cs0_n, ide_cs1_n, ide_rd_n, ide_wr_n;
	logic [4:0] keys_in, kj_in;
	logic       tape_read, vg_intrq, vg_drq, vg_cs_n, vg_wr_ff;
	border_t    border;
	logic       beeper, tapeout, ay_bc1, ay_bdir;
	logic [1:0] rstrom;
	page1m_t    pent1m_page;
	logic       pent1m_rom, pent1m_1m_on, pent1m_ram0_0;

	// combinational outputs caught mid-access
	byte_t      snap_dout;
	ide_word_t  snap_ideout;
	ide_reg_t   snap_ide_a;
	logic       snap_dataout, snap_porthit, snap_ide_rd_n, snap_ide_wr_n;
	logic       snap_idedataout, snap_cs0_n, snap_cs1_n;
	logic       snap_bc1, snap_bdir, snap_vg_cs_n, snap_vg_wr_ff;

	zports_top zports_top_i (.*);

	always #50 zclk = ~zclk; // 100 ns period

	task automatic check(input string name, input logic [15:0] got, input logic [15:0] exp);
		if (got !== exp)
		begin
			$display("MISMATCH at %0t ns: %s got %h, expected %h", $time, name, got, exp);
			$display("Done: errors found");
			$fatal(1, "stopped at the first error");
		end
	endtask

	// idle bus keeps every strobe line high
	task automatic wait_bus_idle;
		int n;
		n = 0;
		while (!(ide_rd_n && ide_wr_n && vg_cs_n))
		begin
			if (n == 8)
			begin
				$display("timeout: IDE or VG strobes stayed active with the bus idle");
				$display("Done: errors found");
				$fatal(1, "bus idle timeout");
			end
			else
			begin
				@(posedge zclk);
				n++;
			end
		end
	endtask

	// z80 access, iorq and rd/wr low for 3 clocks
	task automatic bus_cycle(input io_addr_t addr, input byte_t data, input logic write);
		wait_bus_idle();
		@(posedge zclk);
		#5;
		a      = addr;
		din    = data;
		iorq_n = 1'b0;
		if (write)
			wr_n = 1'b0;
		else
			rd_n = 1'b0;
		@(posedge zclk); // strobe edge
		@(negedge zclk); // mid access, levels settled
		snap_dout       = dout;
		snap_dataout    = dataout;
		snap_porthit    = porthit;
		snap_ide_rd_n   = ide_rd_n;
		snap_ide_wr_n   = ide_wr_n;
		snap_ideout     = ideout;
		snap_idedataout = idedataout;
		snap_ide_a      = ide_a;
		snap_cs0_n      = ide_cs0_n;
		snap_cs1_n      = ide_cs1_n;
		snap_bc1        = ay_bc1;
		snap_bdir       = ay_bdir;
		snap_vg_cs_n    = vg_cs_n;
		snap_vg_wr_ff   = vg_wr_ff; // one-clock strobe, high right now
		repeat (2) @(posedge zclk); // registers loaded on the first
		#5;
		iorq_n = 1'b1;
		wr_n   = 1'b1;
		rd_n   = 1'b1;
	endtask

	task automatic io_write(input io_addr_t addr, input byte_t data);
		bus_cycle(addr, data, 1'b1);
	endtask

	task automatic io_read(input io_addr_t addr);
		bus_cycle(addr, 8'h00, 1'b0);
	endtask

	////////////////////////////////////////////////////////////
	// tests

	task automatic test_reset;
		check("p7ffd", p7ffd, {3'b000, rstrom[0], 4'b0000}); // rom bit from rstrom
		check("peff7", peff7, 8'h00);
		check("border", border, 3'b000);
		check("beeper", beeper, 1'b0);
		check("tapeout", tapeout, 1'b0);
	endtask

	task automatic test_fe;
		byte_t d;
		d = byte_t'($urandom);
		io_write({8'h00, `PORT_FE}, d);
		check("border", border, d[2:0]);
		check("tapeout", tapeout, d[`FE_TAPE]);
		check("beeper", beeper, d[`FE_BEEP]);
		keys_in   = 5'($urandom);
		tape_read = 1'($urandom);
		io_read({8'hFE, `PORT_FE});
		check("dout", snap_dout, {1'b1, tape_read, 1'b0, keys_in});
		check("dataout", snap_dataout, 1'b1);
		check("porthit", snap_porthit, 1'b1);
	endtask

	task automatic test_paging;
		byte_t d1, d2, d3, e;
		d1 = byte_t'($urandom) & 8'hDF; // lock bit clear for now
		io_write(16'h7FFD, d1);
		check("p7ffd", p7ffd, d1);
		check("pent1m_page", pent1m_page, {d1[7:5], d1[2:0]});
		check("pent1m_rom", pent1m_rom, d1[4]);
		e = byte_t'($urandom) | 8'h04; // 1m off
		io_write(16'hEFF7, e);
		check("pent1m_1m_on", pent1m_1m_on, 1'b0);
		check("pent1m_ram0_0", pent1m_ram0_0, e[3]);
		check("peff7", peff7, e & ~8'h4E);
		check("p7ffd", p7ffd, {3'b000, d1[4:0]}); // high page bits masked
		d2 = byte_t'($urandom) | 8'h20; // arms the lock
		io_write(16'h7FFD, d2);
		check("p7ffd", p7ffd, {3'b000, d2[4:0]});
		d3 = ~d2;
		io_write(16'h7FFD, d3); // locked, ignored
		check("p7ffd", p7ffd, {3'b000, d2[4:0]});
		check("pent1m_page", pent1m_page, {d2[7:5], d2[2:0]});
		check("pent1m_rom", pent1m_rom, d2[4]);
	endtask

	task automatic test_ide;
		byte_t     hi, lo;
		ide_word_t w;
		hi = byte_t'($urandom);
		lo = byte_t'($urandom);
		io_write({8'h00, `IDE_11}, hi); // normal order, high first
		io_write({8'h00, `IDE_10}, lo);
		check("ide_wr_n", snap_ide_wr_n, 1'b0);
		check("ideout", snap_ideout, {hi, lo});
		check("idedataout", snap_idedataout, 1'b1);
		lo = byte_t'($urandom);
		hi = byte_t'($urandom);
		io_write({8'h00, `IDE_10}, lo); // divide order, only stored
		check("ide_wr_n", snap_ide_wr_n, 1'b1);
		io_write({8'h00, `IDE_10}, hi);
		check("ide_wr_n", snap_ide_wr_n, 1'b0);
		check("ideout", snap_ideout, {hi, lo});
		w     = ide_word_t'($urandom);
		idein = w;
		io_read({8'h00, `IDE_10});
		check("ide_rd_n", snap_ide_rd_n, 1'b0);
		check("idedataout", snap_idedataout, 1'b0);
		check("ide_cs0_n", snap_cs0_n, 1'b0);
		check("ide_cs1_n", snap_cs1_n, 1'b1);
		check("ide_a", snap_ide_a, 3'b000);
		check("dout", snap_dout, w[7:0]);
		idein = ~w; // high byte must come from the capture
		io_read({8'h00, `IDE_11});
		check("dout", snap_dout, w[15:8]);
		w     = ide_word_t'($urandom);
		idein = w;
		io_read({8'h00, `IDE_10});
		check("dout", snap_dout, w[7:0]);
		idein = ~w;
		io_read({8'h00, `IDE_10}); // divide, second #10
		check("ide_rd_n", snap_ide_rd_n, 1'b1);
		check("idedataout", snap_idedataout, 1'b1);
		check("dout", snap_dout, w[15:8]);
		io_read({8'h00, `IDE_C8}); // alt status, cs1 group
		check("ide_cs1_n", snap_cs1_n, 1'b0);
		check("ide_cs0_n", snap_cs0_n, 1'b1);
		check("ide_a", snap_ide_a, 3'b110);
	endtask

	task automatic test_ay_shadow;
		io_write(16'hFFFD, byte_t'($urandom));
		check("ay_bc1", snap_bc1, 1'b1);
		check("ay_bdir", snap_bdir, 1'b1);
		io_read(16'hFFFD);
		check("dataout", snap_dataout, 1'b0); // ay drives the data itself
		check("porthit", snap_porthit, 1'b1);
		io_write(16'hBFFD, byte_t'($urandom));
		check("ay_bc1", snap_bc1, 1'b0);
		check("ay_bdir", snap_bdir, 1'b1);
		dos      = 1'b1;
		vg_intrq = 1'($urandom);
		vg_drq   = 1'($urandom);
		io_write({8'h00, `VG_COM}, byte_t'($urandom));
		check("vg_cs_n", snap_vg_cs_n, 1'b0);
		check("vg_wr_ff", snap_vg_wr_ff, 1'b0);
		io_write({8'h00, `VG_SYS}, byte_t'($urandom)); // drive/side select
		check("vg_wr_ff", snap_vg_wr_ff, 1'b1);
		io_read({8'h00, `VG_SYS});
		check("dout", snap_dout, {vg_intrq, vg_drq, 6'b111111});
		check("porthit", snap_porthit, 1'b1);
		dos   = 1'b0;
		kj_in = 5'($urandom);
		io_read({8'h00, `VG_TRK}); // no vg outside shadow
		check("porthit", snap_porthit, 1'b0);
		check("vg_cs_n", snap_vg_cs_n, 1'b1);
		io_read({8'h00, `KJOY});
		check("dout", snap_dout, {3'b000, kj_in});
		check("vg_cs_n", snap_vg_cs_n, 1'b1);
	endtask

	////////////////////////////////////////////////////////////
	// run

	initial
	begin
		zclk      = 1'b0;
		rst_n     = 1'b0;
		a         = '0;
		din       = '0;
		iorq_n    = 1'b1;
		rd_n      = 1'b1;
		wr_n      = 1'b1;
		dos       = 1'b0;
		idein     = '0;
		keys_in   = 5'h1F;
		kj_in     = '0;
		mus_in    = '0;
		tape_read = 1'b0;
		vg_intrq  = 1'b0;
		vg_drq    = 1'b0;
		rstrom    = 2'b01; // start from rom 1
		void'($urandom(64));
		repeat (2) @(posedge zclk);
		#5;
		rst_n = 1'b1;
		test_reset();
		test_fe();
		test_paging();
		test_ide();
		test_ay_shadow();
		$display("Done: no errors");
		$finish;
	end

endmodule

`default_nettype wire

//--- ula_ay_ports.sv
/* port fe border/beeper/tape register
   and ay bc1/bdir generation */
`timescale 1ns/1ps
`default_nettype none
`include "zports_params.svh"

module ula_ay_ports import paging_pkg::*; (
	input  wire      zclk,
	input  wire      rst_n,
	port_bus_if.snk  bus,
	output border_t  border,
	output logic     beeper,
	output logic     tapeout,
	output logic     ay_bc1,
	output logic     ay_bdir
);

	logic fe_wr;
	logic fd_port;
	logic pre_bc1, pre_bdir; // address part of ay control

	assign fe_wr = (bus.addr[7:0] == `PORT_FE) && bus.port_wr;

	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			border  <= '0;
			beeper  <= 1'b0;
			tapeout <= 1'b0;
		end
		else if (fe_wr)
		begin
			border  <= bus.data[2:0];
			tapeout <= bus.data[`FE_TAPE];
			beeper  <= bus.data[`FE_BEEP];
		end
	end

	////////////////////////////////////////////////////////////
	// ay: fffd address/read, bffd data write

	assign fd_port  = (bus.addr[7:0] == `PORT_FD);
	assign pre_bc1  = fd_port && (bus.addr[15:14] == 2'b11);
	assign pre_bdir = fd_port && bus.addr[15];     // 11 or 10

	assign ay_bc1  = pre_bc1 & ~bus.iorq_n & (~bus.rd_n | ~bus.wr_n);
	assign ay_bdir = pre_bdir & ~bus.iorq_n & ~bus.wr_n;

endmodule

`default_nettype wire

//--- zports_params.svh
/* port address bytes of the Z80 I/O block,
   register bit positions and reset values */
`ifndef ZPORTS_PARAMS_SVH
`define ZPORTS_PARAMS_SVH

// ula, ay and paging ports, low address byte
`define PORT_FE   8'hFE
`define PORT_FD   8'hFD
`define PORT_F7   8'hF7

// nemo ide ports
`define IDE_10    8'h10 // data, low byte
`define IDE_11    8'h11 // data, high byte
`define IDE_30    8'h30
`define IDE_50    8'h50
`define IDE_70    8'h70
`define IDE_90    8'h90
`define IDE_B0    8'hB0
`define IDE_D0    8'hD0
`define IDE_F0    8'hF0
`define IDE_C8    8'hC8 // cs1 group

// vg93 ports, shadow only
`define VG_COM    8'h1F
`define VG_TRK    8'h3F
`define VG_SEC    8'h5F
`define VG_DAT    8'h7F
`define VG_SYS    8'hFF

`define KJOY      8'h1F // outside shadow
`define KMOUSE    8'hDF
`define RD_IDLE   8'hFF // nobody drives the bus

// register bits and reset values
`define FE_TAPE    3
`define FE_BEEP    4
`define P7FFD_ROM  4
`define P7FFD_LOCK 5 // 48k lock
`define EFF7_LOCK  2 // 1m off, also arms 7ffd lock
`define EFF7_RAM0  3
`define P7FFD_RST  8'h00
`define PEFF7_RST  8'h00

`endif

//--- zports_pkg.sv
/* bus and ide data types of the port block */
`default_nettype none

package zports_pkg;

	// z80 side
	typedef logic [7:0]  byte_t;     // data bus byte
	typedef logic [15:0] io_addr_t;  // full i/o address

	// ide side
	typedef logic [15:0] ide_word_t; // 16 bit ide data
	typedef logic [2:0]  ide_reg_t;  // da2..da0 register select

endpackage

`default_nettype wire

//--- zports_top.sv
/* top level of the z80 port block,
   internal bus and port sub-blocks */
`timescale 1ns/1ps
`default_nettype none

module zports_top import zports_pkg::*, paging_pkg::*; (
	input  wire       zclk,
	input  wire       rst_n,
	// z80 bus
	input  wire io_addr_t a,
	input  wire byte_t    din,
	input  wire       iorq_n,
	input  wire       rd_n,
	input  wire       wr_n,
	input  wire       dos,
	output byte_t     dout,
	output logic      dataout,
	output logic      porthit,
	// ide
	input  wire ide_word_t idein,
	output ide_word_t ideout,
	output logic      idedataout,
	output ide_reg_t  ide_a,
	output logic      ide_cs0_n,
	output logic      ide_cs1_n,
	output logic      ide_rd_n,
	output logic      ide_wr_n,
	// inputs for readback
	input  wire [4:0] keys_in,
	input  wire [4:0] kj_in,
	input  wire byte_t mus_in,
	input  wire       tape_read,
	// vg93
	input  wire       vg_intrq,
	input  wire       vg_drq,
	output logic      vg_cs_n,
	output logic      vg_wr_ff,
	// ula and ay
	output border_t   border,
	output logic      beeper,
	output logic      tapeout,
	output logic      ay_bc1,
	output logic      ay_bdir,
	// paging
	input  wire [1:0] rstrom,
	output byte_t     p7ffd,
	output byte_t     peff7,
	output page1m_t   pent1m_page,
	output logic      pent1m_rom,
	output logic      pent1m_1m_on,
	output logic      pent1m_ram0_0
);

	byte_t ide_rd_data; // bridge to read mux

	port_bus_if bus ();

	io_strobe_gen u_strobe (.zclk(zclk), .rst_n(rst_n), .a(a), .din(din), .iorq_n(iorq_n),
		.rd_n(rd_n), .wr_n(wr_n), .dos(dos), .bus(bus.src));

	port_decoder u_dec (.bus(bus.snk), .ide_rd_data(ide_rd_data), .keys_in(keys_in),
		.tape_read(tape_read), .vg_intrq(vg_intrq), .vg_drq(vg_drq), .kj_in(kj_in),
		.mus_in(mus_in), .dout(dout), .dataout(dataout), .porthit(porthit),
		.vg_cs_n(vg_cs_n), .vg_wr_ff(vg_wr_ff));

	ula_ay_ports u_ula (.zclk(zclk), .rst_n(rst_n), .bus(bus.snk), .border(border),
		.beeper(beeper), .tapeout(tapeout), .ay_bc1(ay_bc1), .ay_bdir(ay_bdir));

	ide_bridge u_ide (.zclk(zclk), .rst_n(rst_n), .bus(bus.snk), .idein(idein),
		.ideout(ideout), .ide_rd_data(ide_rd_data), .idedataout(idedataout),
		.ide_a(ide_a), .ide_cs0_n(ide_cs0_n), .ide_cs1_n(ide_cs1_n),
		.ide_rd_n(ide_rd_n), .ide_wr_n(ide_wr_n));

	mem_pager u_pager (.zclk(zclk), .rst_n(rst_n), .bus(bus.snk), .rstrom(rstrom),
		.p7ffd(p7ffd), .peff7(peff7), .pent1m_page(pent1m_page), .pent1m_rom(pent1m_rom),
		.pent1m_1m_on(pent1m_1m_on), .pent1m_ram0_0(pent1m_ram0_0));

endmodule

`default_nettype wire
